/* Makefile */
TB_TOP = spiPortTopTb

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TB_TOP) -f spiPortTop.f -o $(TB_TOP)

run: build
	./obj_dir/$(TB_TOP)

lint:
	verilator --lint-only -Wall --timing --top-module spiPortTop -f spiPortTop.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* common/spiPkg.sv */
// Shared SPI port definitions
// Sizes for slave words, synchronizers, SCK divider and role capture
// Slave command codes and the received word decode

`default_nettype none

package spiPkg;

	// -------------------------------------------------------------------------
	// Sizes
	// -------------------------------------------------------------------------
	// Slave word and length field
	localparam int lpWordBits   = 32;
	localparam int lpLenBits    = 16;
	// Input pin synchronizer depth
	localparam int lpSyncStages = 3;
	// Master SCK half period in system clocks
	localparam int lpSckHalf    = 4;
	// MOSI update delay after SCK fall
	localparam int lpHoldCycles = 2;
	// Post-reset window for the CS2 role strap
	localparam int lpCapCycles  = 16;

	// -------------------------------------------------------------------------
	// Slave command decode
	// -------------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		cmdNone     = 2'd0,
		cmdCsrWrite = 2'd1,
		cmdCsrRead  = 2'd2,
		cmdMemWrite = 2'd3
	} spiCmd_e;

	// Received word, seen as start address or as command header
	typedef union packed
	{
		logic [lpWordBits-1:0] adrs;
		struct packed
		{
			// Unused upper bits
			logic [5:0]           rsvd;
			spiCmd_e              cmd;
			// Data length in bytes
			logic [lpLenBits-1:0] len;
			// Turnaround byte
			logic [7:0]           dummy;
		} hdr;
	} spiHdrWord_u;

endpackage

`default_nettype wire

/* common/spiSlaveIf.sv */
// Slave word bundle
// One received data word with its address and frame header fields

`timescale 1ns/1ps
`default_nettype none

interface spiSlaveIf;
	import spiPkg::*;

	// Data word and its auto-incremented address
	logic [lpWordBits-1:0] word;
	logic [lpWordBits-1:0] adrs;
	// Header fields of the current frame
	spiCmd_e               cmd;
	logic [lpLenBits-1:0]  len;
	// One-cycle strobe, no back-pressure
	logic                  wordValid;

	modport rx (output word, adrs, cmd, len, wordValid);
	modport host (input word, adrs, cmd, len, wordValid);
endinterface

`default_nettype wire

/* design/spiPortTop.sv */
// SPI port top level
// Role strap, slave receiver and master byte engine
// Split in / out / enable pins and host ports

`timescale 1ns/1ps
`default_nettype none

module spiPortTop
(
	input  logic                          iSysClk,
	input  logic                          rst,
	// SPI pins
	input  logic                          sckIn,
	output logic                          sckOut,
	input  logic                          mosiIn,
	output logic                          mosiOut,
	input  logic                          misoIn,
	output logic                          misoOut,
	input  logic                          cs1In,
	output logic                          cs1Out,
	input  logic                          cs2In,
	output logic                          cs2Out,
	output logic                          mstOe,
	output logic                          slvOe,
	// Master host side
	input  logic                          mstCs1,
	input  logic                          mstCs2,
	input  logic [7:0]                    mstTxByte,
	input  logic                          mstTxValid,
	output logic                          mstTxReady,
	output logic [7:0]                    mstRxByte,
	output logic                          mstRxValid,
	output logic                          masterSel,
	// Slave host side
	input  logic [spiPkg::lpWordBits-1:0] slvTxWord,
	output logic [spiPkg::lpWordBits-1:0] slvWord,
	output logic [spiPkg::lpWordBits-1:0] slvAdrs,
	output spiPkg::spiCmd_e               slvCmd,
	output logic [spiPkg::lpLenBits-1:0]  slvLen,
	output logic                          slvWordValid
);

	logic slaveEn;
	logic mstEn;

	spiSlaveIf slvIf ();

	spiRoleSelect roleSel_i
	(
		.iSysClk   (iSysClk),
		.rst       (rst),
		.cs2In     (cs2In),
		.masterSel (masterSel),
		.slaveEn   (slaveEn),
		.mstEn     (mstEn),
		.mstOe     (mstOe),
		.slvOe     (slvOe)
	);

	spiSlaveRx slaveRx_i
	(
		.iSysClk (iSysClk),
		.rst     (rst),
		.slaveEn (slaveEn),
		.sckIn   (sckIn),
		.mosiIn  (mosiIn),
		.cs1In   (cs1In),
		.txWord  (slvTxWord),
		.misoOut (misoOut),
		.rxIf    (slvIf.rx)
	);

	spiMasterByte masterByte_i
	(
		.iSysClk (iSysClk),
		.rst     (rst),
		.mstEn   (mstEn),
		.txByte  (mstTxByte),
		.txValid (mstTxValid),
		.txReady (mstTxReady),
		.rxByte  (mstRxByte),
		.rxValid (mstRxValid),
		.sckOut  (sckOut),
		.mosiOut (mosiOut),
		.misoIn  (misoIn)
	);

	// Chip selects driven straight by the host
	assign cs1Out = mstCs1;
	assign cs2Out = mstCs2;

	// Slave word bundle out to plain host ports
	assign slvWord      = slvIf.word;
	assign slvAdrs      = slvIf.adrs;
	assign slvCmd       = slvIf.cmd;
	assign slvLen       = slvIf.len;
	assign slvWordValid = slvIf.wordValid;

endmodule

`default_nettype wire

/* design/spiRoleSelect.sv */
// Master / slave role strap
// CS2 synchronizer, post-reset capture window and role latch
// Pin output enables and block enables

`timescale 1ns/1ps
`default_nettype none

module spiRoleSelect
(
	input  logic iSysClk,
	input  logic rst,
	input  logic cs2In,
	output logic masterSel,
	output logic slaveEn,
	output logic mstEn,
	output logic mstOe,
	output logic slvOe
);
	import spiPkg::*;

	logic [lpSyncStages-1:0]            cs2Sync;
	logic [$clog2(lpCapCycles+1)-1:0]   capCnt;
	logic                               capDone;

	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			cs2Sync   <= '0;
			capCnt    <= '0;
			capDone   <= 1'b0;
			masterSel <= 1'b0;
		end
		else
		begin
			cs2Sync <= {cs2Sync[lpSyncStages-2:0], cs2In};
			if (!capDone)
			begin
				if (32'(capCnt) == lpCapCycles - 1)
				begin
					// High strap selects master, held until reset
					capDone   <= 1'b1;
					masterSel <= cs2Sync[lpSyncStages-1];
				end
				else
					capCnt <= capCnt + 1'b1;
			end
		end
	end

	// Everything off during the window
	assign mstEn   = capDone & masterSel;
	assign slaveEn = capDone & ~masterSel;
	// SCK, MOSI and CS pins for master, MISO for slave
	assign mstOe   = mstEn;
	assign slvOe   = slaveEn;

endmodule

`default_nettype wire

/* spi/spiMasterByte.sv */
// SPI master byte engine, Mode 0
// SCK divider and edge counter
// MOSI shifter with hold delay after each falling edge, MISO capture

`timescale 1ns/1ps
`default_nettype none

module spiMasterByte
(
	input  logic       iSysClk,
	input  logic       rst,
	input  logic       mstEn,
	input  logic [7:0] txByte,
	input  logic       txValid,
	output logic       txReady,
	output logic [7:0] rxByte,
	output logic       rxValid,
	output logic       sckOut,
	output logic       mosiOut,
	input  logic       misoIn
);
	import spiPkg::*;

	logic                                busy;
	logic                                accept;
	// SCK generation
	logic [$clog2(lpSckHalf)-1:0]        divCnt;
	logic                                halfTick;
	logic                                sckReg;
	logic [2:0]                          fallCnt;
	// Hold delay before each MOSI step
	logic                                holdAct;
	logic [$clog2(lpHoldCycles+1)-1:0]   holdCnt;
	logic                                holdDone;
	logic [7:0]                          txShift;
	logic [7:0]                          rxShift;

	assign txReady  = mstEn & ~busy;
	assign accept   = txValid & txReady;
	assign halfTick = busy & (32'(divCnt) == lpSckHalf - 1);
	assign holdDone = holdAct & (32'(holdCnt) == lpHoldCycles - 1);

	// -------------------------------------------------------------------------
	// SCK and byte control
	// -------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst || !mstEn)
		begin
			busy    <= 1'b0;
			divCnt  <= '0;
			sckReg  <= 1'b0;
			fallCnt <= '0;
			holdAct <= 1'b0;
			holdCnt <= '0;
			rxValid <= 1'b0;
		end
		else
		begin
			rxValid <= 1'b0;
			if (accept)
			begin
				// SCK starts low
				busy    <= 1'b1;
				divCnt  <= '0;
				sckReg  <= 1'b0;
				fallCnt <= '0;
			end
			else if (halfTick)
			begin
				divCnt <= '0;
				sckReg <= ~sckReg;
				if (sckReg)
				begin
					fallCnt <= fallCnt + 1'b1;
					if (&fallCnt)
					begin
						// Eighth fall ends the byte
						busy    <= 1'b0;
						rxValid <= 1'b1;
					end
					else
					begin
						holdAct <= 1'b1;
						holdCnt <= '0;
					end
				end
			end
			else if (busy)
				divCnt <= divCnt + 1'b1;

			if (holdDone)
				holdAct <= 1'b0;
			else if (holdAct)
				holdCnt <= holdCnt + 1'b1;
		end
	end

	// -------------------------------------------------------------------------
	// Shifters
	// -------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		// MSB on MOSI before the first rise
		if (accept)
			txShift <= txByte;
		else if (holdDone)
			txShift <= {txShift[6:0], 1'b0};

		if (halfTick && !sckReg)
			rxShift <= {rxShift[6:0], misoIn};

		if (halfTick && sckReg && (&fallCnt))
			rxByte <= rxShift;
	end

	assign sckOut  = sckReg;
	assign mosiOut = txShift[7];

endmodule

`default_nettype wire

/* spi/spiSlaveRx.sv */
// SPI slave receiver, Mode 0
// Pin synchronizers and SCK edge detect
// Address / header / data frame machine with address increment
// MISO word shifter

`timescale 1ns/1ps
`default_nettype none

module spiSlaveRx
(
	input  logic                          iSysClk,
	input  logic                          rst,
	input  logic                          slaveEn,
	input  logic                          sckIn,
	input  logic                          mosiIn,
	input  logic                          cs1In,
	input  logic [spiPkg::lpWordBits-1:0] txWord,
	output logic                          misoOut,
	spiSlaveIf.rx                         rxIf
);
	import spiPkg::*;

	// Synchronizer chains, oldest sample at the top
	logic [lpSyncStages-1:0]         sckSync;
	logic [lpSyncStages-1:0]         mosiSync;
	logic [lpSyncStages-1:0]         csSync;
	logic                            sckRise;
	logic                            sckFall;
	logic                            mosiBit;
	logic                            csActive;
	// Falling edges within the current word
	logic [$clog2(lpWordBits)-1:0]   bitCnt;
	logic                            wordEnd;
	// Frame state, neither flag set means address word
	logic                            hdrPhase;
	logic                            dataPhase;
	// Incoming word and next data address
	spiHdrWord_u                     rxShift;
	logic [lpWordBits-1:0]           nextAdrs;
	logic [lpWordBits-1:0]           txShift;

	// -------------------------------------------------------------------------
	// Pin sampling
	// -------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			sckSync <= '0;
			// Chip select idles high
			csSync  <= '1;
		end
		else
		begin
			sckSync <= {sckSync[lpSyncStages-2:0], sckIn};
			csSync  <= {csSync[lpSyncStages-2:0], cs1In};
		end
	end

	always_ff @(posedge iSysClk)
	begin
		mosiSync <= {mosiSync[lpSyncStages-2:0], mosiIn};
	end

	// Edges from the two oldest samples
	assign sckRise  = ~sckSync[lpSyncStages-1] & sckSync[lpSyncStages-2];
	assign sckFall  = sckSync[lpSyncStages-1] & ~sckSync[lpSyncStages-2];
	// MOSI taken at the same depth as the newer SCK sample
	assign mosiBit  = mosiSync[lpSyncStages-2];
	assign csActive = slaveEn & ~csSync[lpSyncStages-1];
	// Last falling edge of a 32-bit word
	assign wordEnd  = csActive & sckFall & (&bitCnt);

	// -------------------------------------------------------------------------
	// Frame machine
	// -------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst || !csActive)
		begin
			// CS high aborts the frame
			bitCnt         <= '0;
			hdrPhase       <= 1'b0;
			dataPhase      <= 1'b0;
			rxIf.cmd       <= cmdNone;
			rxIf.len       <= '0;
			rxIf.wordValid <= 1'b0;
		end
		else
		begin
			rxIf.wordValid <= 1'b0;
			if (sckFall)
				bitCnt <= bitCnt + 1'b1;
			if (wordEnd)
			begin
				if (dataPhase)
					rxIf.wordValid <= 1'b1;
				else if (hdrPhase)
				begin
					// Header word, not reported
					hdrPhase  <= 1'b0;
					dataPhase <= 1'b1;
					rxIf.cmd  <= rxShift.hdr.cmd;
					rxIf.len  <= rxShift.hdr.len;
				end
				else
					hdrPhase <= 1'b1;
			end
		end
	end

	// -------------------------------------------------------------------------
	// Data path
	// -------------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		// MOSI captured on rising SCK, MSB first
		if (csActive && sckRise)
			rxShift.adrs <= {rxShift.adrs[lpWordBits-2:0], mosiBit};

		// Base address from the first word
		if (wordEnd && !hdrPhase && !dataPhase)
			nextAdrs <= rxShift.adrs;

		if (wordEnd && dataPhase)
		begin
			rxIf.word <= rxShift;
			rxIf.adrs <= nextAdrs;
			nextAdrs  <= nextAdrs + lpWordBits'(1);
		end

		// Host word reloaded at each word boundary
		if (!csActive || wordEnd)
			txShift <= txWord;
		else if (sckFall)
			txShift <= {txShift[lpWordBits-2:0], 1'b0};
	end

	assign misoOut = txShift[lpWordBits-1];

endmodule

`default_nettype wire

/* spiPortTop.f */
common/spiPkg.sv
common/spiSlaveIf.sv
spi/spiSlaveRx.sv
spi/spiMasterByte.sv
design/spiRoleSelect.sv
design/spiPortTop.sv
verif/spiPortTopTb.sv

/* verif/spiPortTopTb.sv */
// Testbench for the SPI port top level
// Table of slave frames and master bytes, applied after a reset per row
// External SPI master model, MISO byte model, LCG data words

`timescale 1ns/1ps
`default_nettype none

module spiPortTopTb;
	import spiPkg::*;

	// External master SCK half period in system clocks
	localparam int lpExtHalf = 10;
	localparam int lpRows    = 5;

	typedef struct packed
	{
		logic        isMaster;
		// Partial frame sent and dropped before the real one
		logic        abortFirst;
		logic [31:0] base;
		logic [1:0]  cmd;
		logic [15:0] len;
		int          nWords;
		logic [31:0] txWord;
		// Master row: byte sent on MOSI, byte returned on MISO
		logic [7:0]  mstTx;
		logic [7:0]  mstRx;
	} testRow_t;

	logic        iSysClk = 1'b0;
	logic        rst;
	logic        sckIn;
	logic        sckOut;
	logic        mosiIn;
	logic        mosiOut;
	logic        misoIn;
	logic        misoOut;
	logic        cs1In;
	logic        cs1Out;
	logic        cs2In;
	logic        cs2Out;
	logic        mstOe;
	logic        slvOe;
	logic        mstCs1;
	logic        mstCs2;
	logic [7:0]  mstTxByte;
	logic        mstTxValid;
	logic        mstTxReady;
	logic [7:0]  mstRxByte;
	logic        mstRxValid;
	logic        masterSel;
	logic [31:0] slvTxWord;
	logic [31:0] slvWord;
	logic [31:0] slvAdrs;
	logic [1:0]  slvCmd;
	logic [15:0] slvLen;
	logic        slvWordValid;

	testRow_t    testTable [lpRows];
	logic [31:0] lcgState = 32'd54419;
	int          cycleCnt = 0;
	int          cycleLimit = 1000000;
	// Words seen on the slave host port
	logic [31:0] gotWord [$];
	logic [31:0] gotAdrs [$];
	logic [1:0]  gotCmd [$];
	logic [15:0] gotLen [$];

	spiPortTop dut_i
	(
		.iSysClk      (iSysClk),
		.rst          (rst),
		.sckIn        (sckIn),
		.sckOut       (sckOut),
		.mosiIn       (mosiIn),
		.mosiOut      (mosiOut),
		.misoIn       (misoIn),
		.misoOut      (misoOut),
		.cs1In        (cs1In),
		.cs1Out       (cs1Out),
		.cs2In        (cs2In),
		.cs2Out       (cs2Out),
		.mstOe        (mstOe),
		.slvOe        (slvOe),
		.mstCs1       (mstCs1),
		.mstCs2       (mstCs2),
		.mstTxByte    (mstTxByte),
		.mstTxValid   (mstTxValid),
		.mstTxReady   (mstTxReady),
		.mstRxByte    (mstRxByte),
		.mstRxValid   (mstRxValid),
		.masterSel    (masterSel),
		.slvTxWord    (slvTxWord),
		.slvWord      (slvWord),
		.slvAdrs      (slvAdrs),
		.slvCmd       (slvCmd),
		.slvLen       (slvLen),
		.slvWordValid (slvWordValid)
	);

	always #2 iSysClk = ~iSysClk;

	// Record every reported slave word
	always @(posedge iSysClk)
	begin
		if (slvWordValid)
		begin
			gotWord.push_back(slvWord);
			gotAdrs.push_back(slvAdrs);
			gotCmd.push_back(slvCmd);
			gotLen.push_back(slvLen);
		end
	end

	// Run length guard
	always @(posedge iSysClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt > cycleLimit)
			failRun("Timeout: the run exceeded its cycle limit");
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	task automatic waitCycles(input int n);
		repeat (n) @(posedge iSysClk);
	endtask

	// ------------------------------------------------------------------------
	// Reset and role strap
	// ------------------------------------------------------------------------
	task automatic resetDut(input logic role);
		rst        <= 1'b1;
		cs2In      <= role;
		cs1In      <= 1'b1;
		sckIn      <= 1'b0;
		mstTxValid <= 1'b0;
		mstCs1     <= 1'b1;
		mstCs2     <= 1'b1;
		gotWord.delete();
		gotAdrs.delete();
		gotCmd.delete();
		gotLen.delete();
		waitCycles(5);
		rst <= 1'b0;
	endtask

	task automatic checkRole(input logic role);
		int n;
		n = 0;
		// Both enables stay low through the capture window
		while (!(mstOe || slvOe))
		begin
			@(posedge iSysClk);
			n++;
			if (n > 4 * lpCapCycles)
				failRun("Timeout: no output enable after the role capture window");
		end
		assert (n >= lpCapCycles)
		else failRun($sformatf("ERROR at %0t ns: enable after %0d cycles", $time, n));
		assert ((mstOe ^ slvOe) && (mstOe == role) && (masterSel == role))
		else failRun($sformatf("ERROR at %0t ns: role %b mstOe %b slvOe %b masterSel %b",
			$time, role, mstOe, slvOe, masterSel));
	endtask

	// ------------------------------------------------------------------------
	// External master driving the slave, Mode 0, MSB first
	// ------------------------------------------------------------------------
	task automatic shiftSlaveBits(input logic [31:0] data, input int nBits,
		output logic [31:0] sampled);
		sampled = '0;
		for (int i = 0; i < nBits; i++)
		begin
			mosiIn <= data[31-i];
			waitCycles(lpExtHalf);
			sckIn   <= 1'b1;
			sampled = {sampled[30:0], misoOut};
			waitCycles(lpExtHalf);
			sckIn <= 1'b0;
		end
	endtask

	task automatic runSlaveFrame(input int r);
		logic [31:0] hdr;
		logic [31:0] misoWord;
		logic [31:0] expWord [$];
		logic [31:0] w;
		hdr = {6'b0, testTable[r].cmd, testTable[r].len, 8'h00};
		if (testTable[r].abortFirst)
		begin
			// Dropped frame, CS rises inside the header word
			cs1In <= 1'b0;
			waitCycles(lpExtHalf);
			shiftSlaveBits(~testTable[r].base, 32, misoWord);
			shiftSlaveBits(~hdr, 12, misoWord);
			waitCycles(lpExtHalf);
			cs1In <= 1'b1;
			waitCycles(2 * lpExtHalf);
		end
		cs1In <= 1'b0;
		waitCycles(lpExtHalf);
		shiftSlaveBits(testTable[r].base, 32, misoWord);
		shiftSlaveBits(hdr, 32, misoWord);
		for (int k = 0; k < testTable[r].nWords; k++)
		begin
			w = nextRand();
			expWord.push_back(w);
			shiftSlaveBits(w, 32, misoWord);
			assert (misoWord == testTable[r].txWord)
			else failRun($sformatf("ERROR at %0t ns: MISO word %0d is %h, expected %h",
				$time, k, misoWord, testTable[r].txWord));
		end
		waitCycles(lpExtHalf);
		cs1In <= 1'b1;
		waitCycles(2 * lpExtHalf);

		assert (gotWord.size() == testTable[r].nWords)
		else failRun($sformatf("ERROR at %0t ns: %0d word pulses, expected %0d",
			$time, gotWord.size(), testTable[r].nWords));
		for (int k = 0; k < testTable[r].nWords; k++)
		begin
			assert (gotWord[k] == expWord[k] && gotAdrs[k] == testTable[r].base + 32'(k))
			else failRun($sformatf("ERROR at %0t ns: word %0d got %h @ %h, expected %h @ %h",
				$time, k, gotWord[k], gotAdrs[k], expWord[k], testTable[r].base + 32'(k)));
			assert (gotCmd[k] == testTable[r].cmd && gotLen[k] == testTable[r].len)
			else failRun($sformatf("ERROR at %0t ns: header cmd %0d len %0d, expected %0d %0d",
				$time, gotCmd[k], gotLen[k], testTable[r].cmd, testTable[r].len));
		end
	endtask

	// ------------------------------------------------------------------------
	// Master byte against a MISO model
	// ------------------------------------------------------------------------
	task automatic runMasterByte(input int r);
		logic [7:0] rxExp;
		logic [7:0] seenMosi;
		logic       prevSck;
		logic       done;
		int         waitCnt;
		int         riseCnt;
		int         fallCnt;
		rxExp    = testTable[r].mstRx;
		seenMosi = '0;
		prevSck  = 1'b0;
		done     = 1'b0;
		waitCnt  = 0;
		riseCnt  = 0;
		fallCnt  = 0;
		mstCs1    <= 1'b0;
		mstCs2    <= 1'b1;
		misoIn    <= rxExp[7];
		mstTxByte <= testTable[r].mstTx;
		@(posedge iSysClk);
		while (!mstTxReady)
		begin
			@(posedge iSysClk);
			waitCnt++;
			if (waitCnt > 50)
				failRun("Timeout: master never became ready");
		end
		mstTxValid <= 1'b1;
		@(posedge iSysClk);
		// Accept edge
		mstTxValid <= 1'b0;
		waitCnt = 0;
		while (!done)
		begin
			@(posedge iSysClk);
			waitCnt++;
			if (waitCnt > 16 * lpSckHalf + 20)
				failRun("Timeout: master byte never completed");
			assert (cs1Out == 1'b0 && cs2Out == 1'b1)
			else failRun($sformatf("ERROR at %0t ns: cs1Out %b cs2Out %b do not follow host",
				$time, cs1Out, cs2Out));
			if (mstRxValid)
			begin
				done = 1'b1;
				assert (mstTxReady && mstRxByte == rxExp)
				else failRun($sformatf("ERROR at %0t ns: rx byte %h ready %b, expected %h",
					$time, mstRxByte, mstTxReady, rxExp));
			end
			else
			begin
				assert (!mstTxReady)
				else failRun($sformatf("ERROR at %0t ns: ready high during a byte", $time));
			end
			if (sckOut && !prevSck)
			begin
				seenMosi = {seenMosi[6:0], mosiOut};
				riseCnt++;
			end
			if (!sckOut && prevSck)
			begin
				fallCnt++;
				// Next MISO bit after each falling SCK
				if (fallCnt < 8)
					misoIn <= rxExp[7-fallCnt];
			end
			prevSck = sckOut;
		end
		assert (riseCnt == 8 && seenMosi == testTable[r].mstTx)
		else failRun($sformatf("ERROR at %0t ns: MOSI %h over %0d rises, expected %h",
			$time, seenMosi, riseCnt, testTable[r].mstTx));
		// Opposite levels on the two chip selects
		mstCs1 <= 1'b1;
		mstCs2 <= 1'b0;
		waitCycles(2);
		assert (cs1Out == 1'b1 && cs2Out == 1'b0 && gotWord.size() == 0)
		else failRun($sformatf("ERROR at %0t ns: cs1Out %b cs2Out %b, slave pulses %0d",
			$time, cs1Out, cs2Out, gotWord.size()));
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		int limit;
		rst        <= 1'b1;
		sckIn      <= 1'b0;
		mosiIn     <= 1'b0;
		misoIn     <= 1'b0;
		cs1In      <= 1'b1;
		cs2In      <= 1'b0;
		mstCs1     <= 1'b1;
		mstCs2     <= 1'b1;
		mstTxByte  <= '0;
		mstTxValid <= 1'b0;
		slvTxWord  <= '0;

		// Role, abort, base, cmd, len, words, slave tx word, master tx, master rx
		testTable[0] = '{1'b0, 1'b0, 32'h0000_1000, 2'd3, 16'd16, 4, 32'hA5C3_0F96, 8'h00, 8'h00};
		testTable[1] = '{1'b1, 1'b0, 32'h0, 2'd0, 16'd0, 0, 32'h0, 8'hB4, 8'h3C};
		testTable[2] = '{1'b0, 1'b1, 32'h8000_FFFE, 2'd1, 16'd8, 3, 32'h1234_5678, 8'h00, 8'h00};
		testTable[3] = '{1'b1, 1'b0, 32'h0, 2'd0, 16'd0, 0, 32'h0, 8'h5A, 8'hE1};
		testTable[4] = '{1'b0, 1'b0, 32'hFFFF_FFFF, 2'd2, 16'd4, 2, 32'h8000_0001, 8'h00, 8'h00};

		// Bit time of the external master is 2 * lpExtHalf cycles
		limit = 1000;
		for (int r = 0; r < lpRows; r++)
			limit += (testTable[r].nWords + 2 + (testTable[r].abortFirst ? 2 : 0)) * 32 * 20
				+ 5 + 2 * lpCapCycles + 100;
		cycleLimit = limit;

		for (int r = 0; r < lpRows; r++)
		begin
			slvTxWord <= testTable[r].txWord;
			resetDut(testTable[r].isMaster);
			checkRole(testTable[r].isMaster);
			if (testTable[r].isMaster)
				runMasterByte(r);
			else
				runSlaveFrame(r);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
